//--- sram_io_reg_pkg.sv
// Host register map. Bit positions must match the host driver and the chip pinout
`default_nettype none

package sram_io_reg_pkg;

    // ----------------------------------------
    // Host bus
    // ----------------------------------------
    localparam int bus_width = 32;            // All read and write buses

    // ----------------------------------------
    // Control word bits (write only)
    // ----------------------------------------
    localparam int ctrl_bgn_bit  = 0;
    localparam int load_bit      = 1;         // 0 to 1 starts a transfer
    localparam int mod0_bit      = 2;
    localparam int mod1_bit      = 3;
    localparam int app_done_bit  = 4;
    localparam int rst_n_bit     = 6;         // Chip reset, active low
    localparam int cpu_wait_bit  = 7;
    localparam int test_mux_lsb  = 8;         // Three bits wide
    localparam int clk_stop_bit  = 11;

    // Status word bits (read only)
    localparam int stat_rdy_bit       = 0;
    localparam int stat_nxt_end_bit   = 1;
    localparam int stat_nxt_cont_bit  = 2;
    localparam int stat_app_start_bit = 3;
    localparam int stat_so_bit        = 4;
    localparam int stat_busy_bit      = 5;

    // Mode codes that start a serial transfer
    localparam logic [1:0] mode_load_to_chip   = 2'b00;
    localparam logic [1:0] mode_read_from_chip = 2'b10;

endpackage

`default_nettype wire

//--- sram_io_frame_pkg.sv
// Serial frame layout. Address sits above data and bit 0 leaves the FPGA first
`default_nettype none

package sram_io_frame_pkg;

    localparam int frame_addr_width = 10;
    localparam int frame_data_width = 8;
    localparam int frame_width      = frame_addr_width + frame_data_width;

    // Same 18 bits, seen as a shift vector or as address and data fields
    typedef struct packed {
        logic [frame_addr_width-1:0] addr;    // Upper bits
        logic [frame_data_width-1:0] data;    // Lower bits
    } sram_frame_fields_t;

    typedef union packed {
        logic [frame_width-1:0] raw;          // Shift register view
        sram_frame_fields_t     fields;       // Readback view
    } sram_frame_u;

endpackage

`default_nettype wire

//--- sram_io_ctrl_decode.sv
// Host write decode. Writes land at the strobe edge and there is no back-pressure
`timescale 1ns/1ps
`default_nettype none

module sram_io_ctrl_decode
    import sram_io_reg_pkg::*;
    import sram_io_frame_pkg::*;
#(
    parameter int clk_width       = 8,
    parameter int default_cntsclk = 0
)
(
    input  logic                        csi_clk,
    input  logic                        rsi_reset_n,

    input  logic [bus_width-1:0]        cpuctrl_writedata,
    input  logic                        cpuctrl_write,
    input  logic [bus_width-1:0]        cntsclk_writedata,
    input  logic                        cntsclk_write,
    input  logic [bus_width-1:0]        sram_addr_writedata,
    input  logic                        sram_addr_write,
    input  logic [bus_width-1:0]        sram_data_writedata,
    input  logic                        sram_data_write,

    output logic                        ctrl_bgn,
    output logic [1:0]                  ctrl_mode,
    output logic                        rst_n_out,
    output logic                        cpu_wait,
    output logic [2:0]                  test_mux,
    output logic                        app_done,
    output logic                        clk_stop,

    output logic [frame_addr_width-1:0] sram_addr,
    output logic [frame_data_width-1:0] sram_data,
    output logic [clk_width-1:0]        cntsclk,

    output logic                        load_level,
    output logic                        load_pulse
);

    // ----------------------------------------
    // Control word and divider value
    // ----------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl_bgn   <= 1'b0;
            ctrl_mode  <= 2'b00;
            rst_n_out  <= 1'b0;                // Chip held in reset
            cpu_wait   <= 1'b0;
            test_mux   <= 3'b000;
            app_done   <= 1'b0;
            clk_stop   <= 1'b0;
            load_level <= 1'b0;
            load_pulse <= 1'b0;
            cntsclk    <= clk_width'(default_cntsclk);
        end
        else
        begin
            load_pulse <= 1'b0;
            if (cpuctrl_write)
            begin
                ctrl_bgn   <= cpuctrl_writedata[ctrl_bgn_bit];
                ctrl_mode  <= {cpuctrl_writedata[mod1_bit], cpuctrl_writedata[mod0_bit]};
                rst_n_out  <= cpuctrl_writedata[rst_n_bit];
                cpu_wait   <= cpuctrl_writedata[cpu_wait_bit];
                test_mux   <= cpuctrl_writedata[test_mux_lsb +: 3];
                app_done   <= cpuctrl_writedata[app_done_bit];
                clk_stop   <= cpuctrl_writedata[clk_stop_bit];
                load_level <= cpuctrl_writedata[load_bit];
                // Only a 0 to 1 change of the load bit starts a transfer
                load_pulse <= cpuctrl_writedata[load_bit] & ~load_level;
            end
            if (cntsclk_write)
                cntsclk <= cntsclk_writedata[clk_width-1:0];
        end
    end

    // Frame source registers
    always_ff @(posedge csi_clk)
    begin
        if (sram_addr_write)
            sram_addr <= sram_addr_writedata[frame_addr_width-1:0];
        if (sram_data_write)
            sram_data <= sram_data_writedata[frame_data_width-1:0];
    end

endmodule

`default_nettype wire

//--- sram_io_clock_gen.sv
// Chip clock divider. The period is 2*(cntsclk+1) host cycles and clk_stop parks it low
`timescale 1ns/1ps
`default_nettype none

module sram_io_clock_gen #(
    parameter int clk_width = 8
)
(
    input  logic                 csi_clk,
    input  logic                 rsi_reset_n,
    input  logic [clk_width-1:0] cntsclk,
    input  logic                 clk_stop,
    output logic                 chip_clk,
    output logic                 fall_en
);

    logic [clk_width-1:0] div_cnt;
    logic                 div_match;

    // A lowered divider value must not leave the count stuck above it
    assign div_match = (div_cnt >= cntsclk);

    // ----------------------------------------
    // Divider count and chip clock
    // ----------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            div_cnt  <= '0;
            chip_clk <= 1'b0;
        end
        else if (clk_stop)
        begin
            chip_clk <= 1'b0;                // Count frozen while stopped
        end
        else if (div_match)
        begin
            div_cnt  <= '0;
            chip_clk <= ~chip_clk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Stands in for the falling edge of the chip clock
    assign fall_en = div_match & chip_clk & ~clk_stop;

endmodule

`default_nettype wire

//--- sram_io_shift_engine.sv
// Serial frame engine. Shifts only on chip clock falls and drops a load while busy
`timescale 1ns/1ps
`default_nettype none

module sram_io_shift_engine
    import sram_io_reg_pkg::*;
    import sram_io_frame_pkg::*;
(
    input  logic                        csi_clk,
    input  logic                        rsi_reset_n,
    input  logic                        fall_en,
    input  logic                        load_pulse,
    input  logic [1:0]                  ctrl_mode,
    input  logic [frame_addr_width-1:0] sram_addr,
    input  logic [frame_data_width-1:0] sram_data,
    input  logic                        ctrl_so,
    output sram_frame_u                 frame,
    output logic                        busy,
    output logic                        ctrl_si
);

    logic       pending;                       // Load seen, waiting for a fall
    logic [4:0] bit_cnt;
    logic       active;

    assign active = pending | (bit_cnt != 5'd0);

    // ----------------------------------------
    // Frame register and bit counter
    // ----------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            pending   <= 1'b0;
            bit_cnt   <= 5'd0;
            frame.raw <= '0;
        end
        else
        begin
            if (load_pulse && !active)
                pending <= 1'b1;

            if (fall_en)
            begin
                if (pending)
                begin
                    pending <= 1'b0;
                    case (ctrl_mode)
                        mode_load_to_chip:
                        begin
                            frame.fields.addr <= sram_addr;
                            frame.fields.data <= sram_data;
                            bit_cnt           <= 5'(frame_width - 1);
                        end
                        mode_read_from_chip:
                        begin
                            // Chip output is already valid at the first fall
                            frame.raw <= {ctrl_so, frame.raw[frame_width-1:1]};
                            bit_cnt   <= 5'(frame_width - 1);
                        end
                        default:
                            bit_cnt <= 5'd0;   // Other modes cancel
                    endcase
                end
                else if (bit_cnt != 5'd0)
                begin
                    frame.raw <= {ctrl_so, frame.raw[frame_width-1:1]};
                    bit_cnt   <= bit_cnt - 5'd1;
                end
            end
        end
    end

    assign busy    = load_pulse | active;     // Up in the load cycle itself
    assign ctrl_si = frame.raw[0];            // LSB leaves first

endmodule

`default_nettype wire

//--- sram_io_readback.sv
// Read side. All buses are combinational and unused upper bits read as zero
`timescale 1ns/1ps
`default_nettype none

module sram_io_readback
    import sram_io_reg_pkg::*;
    import sram_io_frame_pkg::*;
(
    input  sram_frame_u          frame,
    input  logic                 busy,
    input  logic                 ctrl_rdy,
    input  logic                 ctrl_nxt_end,
    input  logic                 ctrl_nxt_cont,
    input  logic                 app_start,
    input  logic                 ctrl_so,
    output logic [bus_width-1:0] cpustat_readdata,
    output logic [bus_width-1:0] sram_addr_readdata,
    output logic [bus_width-1:0] sram_data_readdata
);

    // Status word
    always_comb
    begin
        cpustat_readdata                     = '0;
        cpustat_readdata[stat_rdy_bit]       = ctrl_rdy;
        cpustat_readdata[stat_nxt_end_bit]   = ctrl_nxt_end;
        cpustat_readdata[stat_nxt_cont_bit]  = ctrl_nxt_cont;
        cpustat_readdata[stat_app_start_bit] = app_start;
        cpustat_readdata[stat_so_bit]        = ctrl_so;
        cpustat_readdata[stat_busy_bit]      = busy;
    end

    // Field view of the frame
    assign sram_addr_readdata = {{(bus_width-frame_addr_width){1'b0}}, frame.fields.addr};
    assign sram_data_readdata = {{(bus_width-frame_data_width){1'b0}}, frame.fields.data};

endmodule

`default_nettype wire

//--- sram_io_ctrl_top.sv
// SRAM IO bridge top. Single clock domain on csi_clk and the chip clock is always divided
`timescale 1ns/1ps
`default_nettype none

module sram_io_ctrl_top
    import sram_io_reg_pkg::*;
    import sram_io_frame_pkg::*;
#(
    parameter int clk_width       = 8,
    parameter int default_cntsclk = 0
)
(
    input  logic                 csi_clk,
    input  logic                 rsi_reset_n,

    // Host side
    input  logic [bus_width-1:0] cpuctrl_writedata,
    input  logic                 cpuctrl_write,
    input  logic [bus_width-1:0] cntsclk_writedata,
    input  logic                 cntsclk_write,
    input  logic [bus_width-1:0] sram_addr_writedata,
    input  logic                 sram_addr_write,
    input  logic [bus_width-1:0] sram_data_writedata,
    input  logic                 sram_data_write,
    output logic [bus_width-1:0] cpustat_readdata,
    output logic [bus_width-1:0] sram_addr_readdata,
    output logic [bus_width-1:0] sram_data_readdata,

    // Chip side
    output logic                 ctrl_bgn_export,
    output logic                 mod0_export,
    output logic                 mod1_export,
    output logic                 load_export,
    output logic                 ctrl_si_export,
    output logic                 rst_n_export,
    output logic                 cpu_wait_export,
    output logic [2:0]           test_mux_export,
    output logic                 app_done_export,
    output logic                 chip_clk_export,
    input  logic                 ctrl_so_export,
    input  logic                 ctrl_rdy_export,
    input  logic                 ctrl_nxt_end_export,
    input  logic                 ctrl_nxt_cont_export,
    input  logic                 app_start_export
);

    logic [1:0]                  ctrl_mode;
    logic                        clk_stop;
    logic [clk_width-1:0]        cntsclk;
    logic [frame_addr_width-1:0] sram_addr;
    logic [frame_data_width-1:0] sram_data;
    logic                        load_pulse;
    logic                        fall_en;
    logic                        busy;
    sram_frame_u                 frame;

    sram_io_ctrl_decode #(
        .clk_width       (clk_width),
        .default_cntsclk (default_cntsclk)
    ) sram_io_ctrl_decode_i (
        .csi_clk             (csi_clk),
        .rsi_reset_n         (rsi_reset_n),
        .cpuctrl_writedata   (cpuctrl_writedata),
        .cpuctrl_write       (cpuctrl_write),
        .cntsclk_writedata   (cntsclk_writedata),
        .cntsclk_write       (cntsclk_write),
        .sram_addr_writedata (sram_addr_writedata),
        .sram_addr_write     (sram_addr_write),
        .sram_data_writedata (sram_data_writedata),
        .sram_data_write     (sram_data_write),
        .ctrl_bgn            (ctrl_bgn_export),
        .ctrl_mode           (ctrl_mode),
        .rst_n_out           (rst_n_export),
        .cpu_wait            (cpu_wait_export),
        .test_mux            (test_mux_export),
        .app_done            (app_done_export),
        .clk_stop            (clk_stop),
        .sram_addr           (sram_addr),
        .sram_data           (sram_data),
        .cntsclk             (cntsclk),
        .load_level          (load_export),
        .load_pulse          (load_pulse)
    );

    sram_io_clock_gen #(
        .clk_width (clk_width)
    ) sram_io_clock_gen_i (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .cntsclk     (cntsclk),
        .clk_stop    (clk_stop),
        .chip_clk    (chip_clk_export),
        .fall_en     (fall_en)
    );

    sram_io_shift_engine sram_io_shift_engine_i (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .fall_en     (fall_en),
        .load_pulse  (load_pulse),
        .ctrl_mode   (ctrl_mode),
        .sram_addr   (sram_addr),
        .sram_data   (sram_data),
        .ctrl_so     (ctrl_so_export),
        .frame       (frame),
        .busy        (busy),
        .ctrl_si     (ctrl_si_export)
    );

    sram_io_readback sram_io_readback_i (
        .frame              (frame),
        .busy               (busy),
        .ctrl_rdy           (ctrl_rdy_export),
        .ctrl_nxt_end       (ctrl_nxt_end_export),
        .ctrl_nxt_cont      (ctrl_nxt_cont_export),
        .app_start          (app_start_export),
        .ctrl_so            (ctrl_so_export),
        .cpustat_readdata   (cpustat_readdata),
        .sram_addr_readdata (sram_addr_readdata),
        .sram_data_readdata (sram_data_readdata)
    );

    // ----------------------------------------
    // Mode pins
    // ----------------------------------------
    // Serial modes 00 and 10 both show 00 on the pins
    assign mod0_export = ctrl_mode[0];
    assign mod1_export = ctrl_mode[0] ? ctrl_mode[1] : 1'b0;

endmodule

`default_nettype wire

//--- tb_sram_io_ctrl.sv
// Runs from sram_io_golden.txt in the project root; ctrl_so is looped back from ctrl_si
`timescale 1ns/1ps
`default_nettype none

module tb_sram_io_ctrl
    import sram_io_reg_pkg::*;
();

    localparam int clk_width       = 8;
    localparam int default_cntsclk = 3;        // Holds chip_clk low over the first checks
    localparam int clk_period_ns   = 10;
    localparam int max_cmds        = 128;
    localparam int max_wait_cycles = 19 * 2 * (2 ** clk_width);  // 19 periods, top divider

    logic                 csi_clk;
    logic                 rsi_reset_n;
    logic [bus_width-1:0] cpuctrl_writedata;
    logic                 cpuctrl_write;
    logic [bus_width-1:0] cntsclk_writedata;
    logic                 cntsclk_write;
    logic [bus_width-1:0] sram_addr_writedata;
    logic                 sram_addr_write;
    logic [bus_width-1:0] sram_data_writedata;
    logic                 sram_data_write;
    logic [bus_width-1:0] cpustat_readdata;
    logic [bus_width-1:0] sram_addr_readdata;
    logic [bus_width-1:0] sram_data_readdata;
    logic                 ctrl_bgn_export;
    logic                 mod0_export;
    logic                 mod1_export;
    logic                 load_export;
    logic                 ctrl_si_export;
    logic                 rst_n_export;
    logic                 cpu_wait_export;
    logic [2:0]           test_mux_export;
    logic                 app_done_export;
    logic                 chip_clk_export;
    logic                 ctrl_so_export;
    logic                 ctrl_rdy_export;
    logic                 ctrl_nxt_end_export;
    logic                 ctrl_nxt_cont_export;
    logic                 app_start_export;

    logic [39:0]          golden_mem [0:max_cmds-1];
    logic                 golden_loaded = 1'b0;
    logic                 exp_frame_lsb;       // Frame bit 0, the serial output bit
    int                   seed;
    int                   num_cmds;
    int                   check_cnt;
    int                   mismatch_cnt;
    int                   other_err_cnt;
    longint               watchdog_ns;

    assign ctrl_so_export = ctrl_si_export;    // Serial loopback

    sram_io_ctrl_top #(
        .clk_width       (clk_width),
        .default_cntsclk (default_cntsclk)
    ) sram_io_ctrl_top_i (
        .csi_clk              (csi_clk),
        .rsi_reset_n          (rsi_reset_n),
        .cpuctrl_writedata    (cpuctrl_writedata),
        .cpuctrl_write        (cpuctrl_write),
        .cntsclk_writedata    (cntsclk_writedata),
        .cntsclk_write        (cntsclk_write),
        .sram_addr_writedata  (sram_addr_writedata),
        .sram_addr_write      (sram_addr_write),
        .sram_data_writedata  (sram_data_writedata),
        .sram_data_write      (sram_data_write),
        .cpustat_readdata     (cpustat_readdata),
        .sram_addr_readdata   (sram_addr_readdata),
        .sram_data_readdata   (sram_data_readdata),
        .ctrl_bgn_export      (ctrl_bgn_export),
        .mod0_export          (mod0_export),
        .mod1_export          (mod1_export),
        .load_export          (load_export),
        .ctrl_si_export       (ctrl_si_export),
        .rst_n_export         (rst_n_export),
        .cpu_wait_export      (cpu_wait_export),
        .test_mux_export      (test_mux_export),
        .app_done_export      (app_done_export),
        .chip_clk_export      (chip_clk_export),
        .ctrl_so_export       (ctrl_so_export),
        .ctrl_rdy_export      (ctrl_rdy_export),
        .ctrl_nxt_end_export  (ctrl_nxt_end_export),
        .ctrl_nxt_cont_export (ctrl_nxt_cont_export),
        .app_start_export     (app_start_export)
    );

    initial
    begin
        csi_clk = 1'b0;
        forever #(clk_period_ns / 2) csi_clk = ~csi_clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Strobes last one cycle
    task automatic next_cycle();
        @(negedge csi_clk);
        cpuctrl_write   = 1'b0;
        cntsclk_write   = 1'b0;
        sram_addr_write = 1'b0;
        sram_data_write = 1'b0;
    endtask

    task automatic drive_status();
        logic [3:0] rnd;
        rnd                  = 4'($random(seed));
        ctrl_rdy_export      = rnd[0];
        ctrl_nxt_end_export  = rnd[1];
        ctrl_nxt_cont_export = rnd[2];
        app_start_export     = rnd[3];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_status(input logic [31:0] busy_word);
        logic [bus_width-1:0] exp;
        exp                     = busy_word;   // Only the busy bit comes from the file
        exp[stat_rdy_bit]       = ctrl_rdy_export;
        exp[stat_nxt_end_bit]   = ctrl_nxt_end_export;
        exp[stat_nxt_cont_bit]  = ctrl_nxt_cont_export;
        exp[stat_app_start_bit] = app_start_export;
        exp[stat_so_bit]        = exp_frame_lsb;
        check_value("cpustat_readdata", cpustat_readdata, exp);
    endtask

    task automatic check_pins(input logic [31:0] exp);
        logic [10:0] pins;
        pins = {chip_clk_export, app_done_export, test_mux_export, cpu_wait_export,
                rst_n_export, load_export, mod1_export, mod0_export, ctrl_bgn_export};
        check_value("pin_vector", 32'(pins), exp);
    endtask

    task automatic wait_busy_clear();
        int waited;
        waited = 0;
        while (cpustat_readdata[stat_busy_bit] && waited < max_wait_cycles)
        begin
            drive_status();
            next_cycle();
            waited++;
        end
        assert (!cpustat_readdata[stat_busy_bit])
        else
        begin
            $display("Transfer did not finish, busy still set after %0d cycles", waited);
            other_err_cnt++;
        end
    endtask

    task automatic execute_command(input logic [39:0] cmd);
        logic [3:0]  op;
        logic [3:0]  sel;
        logic [31:0] val;
        op  = cmd[39:36];
        sel = cmd[35:32];
        val = cmd[31:0];
        case (op)
            4'h1:
            begin
                case (sel)
                    4'h0:
                    begin
                        cpuctrl_writedata = val;
                        cpuctrl_write     = 1'b1;
                    end
                    4'h1:
                    begin
                        cntsclk_writedata = val;
                        cntsclk_write     = 1'b1;
                    end
                    4'h2:
                    begin
                        sram_addr_writedata = val;
                        sram_addr_write     = 1'b1;
                    end
                    4'h3:
                    begin
                        sram_data_writedata = val;
                        sram_data_write     = 1'b1;
                    end
                    default:
                    begin
                        $display("Golden file names an unknown register %0d", sel);
                        other_err_cnt++;
                    end
                endcase
            end
            4'h2: wait_busy_clear();
            4'h3:
            begin
                if (sel == 4'h1)
                    check_value("sram_addr_readdata", sram_addr_readdata, val);
                else if (sel == 4'h2)
                begin
                    check_value("sram_data_readdata", sram_data_readdata, val);
                    exp_frame_lsb = val[0];   // Data LSB is the bit sent on ctrl_si
                end
                else
                begin
                    $display("Golden file names an unknown read bus %0d", sel);
                    other_err_cnt++;
                end
            end
            4'h4: check_status(val);
            4'h5: check_pins(val);
            4'h6:
            begin
                repeat (val)
                begin
                    drive_status();
                    next_cycle();
                end
            end
            default:
            begin
                $display("Golden file holds an unknown command %h", cmd);
                other_err_cnt++;
            end
        endcase
    endtask

    // ----------------------------------------
    // Command sequencer
    // ----------------------------------------
    initial
    begin : sequencer
        int idx;
        seed                = 32'h6010_d7c7;
        check_cnt           = 0;
        mismatch_cnt        = 0;
        other_err_cnt       = 0;
        exp_frame_lsb       = 1'b0;           // Frame clears in reset
        rsi_reset_n         = 1'b0;
        cpuctrl_writedata   = '0;
        cpuctrl_write       = 1'b0;
        cntsclk_writedata   = '0;
        cntsclk_write       = 1'b0;
        sram_addr_writedata = '0;
        sram_addr_write     = 1'b0;
        sram_data_writedata = '0;
        sram_data_write     = 1'b0;
        drive_status();

        $readmemh("sram_io_golden.txt", golden_mem);
        num_cmds = 0;
        while (num_cmds < max_cmds && !$isunknown(golden_mem[num_cmds]) &&
               golden_mem[num_cmds][39:36] != 4'h0)
            num_cmds++;
        assert (num_cmds < max_cmds && golden_mem[num_cmds] === 40'h0)
        else
        begin
            $display("Golden file is missing its end command");
            other_err_cnt++;
        end
        watchdog_ns   = (longint'(num_cmds) * max_wait_cycles + 1000) * clk_period_ns;
        golden_loaded = 1'b1;

        repeat (16) @(negedge csi_clk);
        rsi_reset_n = 1'b1;

        for (idx = 0; idx < num_cmds; idx++)
        begin
            next_cycle();
            execute_command(golden_mem[idx]);
            drive_status();                   // After the checks of this cycle
        end

        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Scales with the number of commands in the file
    initial
    begin : watchdog
        wait (golden_loaded === 1'b1);
        #(watchdog_ns);
        $display("Watchdog expired before the command list finished");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
sram_io_reg_pkg.sv
sram_io_frame_pkg.sv
sram_io_ctrl_decode.sv
sram_io_clock_gen.sv
sram_io_shift_engine.sv
sram_io_readback.sv
sram_io_ctrl_top.sv
tb_sram_io_ctrl.sv

//--- sram_io_golden.txt
// Columns op_sel_value. op 1 write reg sel (0 ctrl, 1 cntsclk, 2 addr, 3 data), 2 wait busy clear,
// 3 check read bus (1 addr, 2 data), 4 check status (value holds busy), 5 check pins, 6 idle, 0 end
5_0_00000000
3_1_00000000
3_2_00000000
4_0_00000000
// Level pins with the chip clock stopped
1_0_00000dd5
6_0_00000002
5_0_00000373
1_0_0000080c
6_0_00000001
5_0_00000006
1_0_00000a08
6_0_00000001
5_0_00000080
// Load to chip, divider 0
1_1_00000000
1_2_000002b5
1_3_0000003c
1_0_00000002
4_0_00000020
2_0_00000000
3_1_0000016a
3_2_00000079
4_0_00000000
// Read from chip, divider 2
1_1_00000002
1_0_00000000
1_0_0000000a
2_0_00000000
3_1_0000016a
3_2_00000079
// Load to chip, divider 5
1_2_000000f1
1_3_000000a6
1_1_00000005
1_0_00000000
1_0_00000002
2_0_00000000
3_1_000001e3
3_2_0000004c
4_0_00000000
// Load to chip, largest divider
1_2_000003ff
1_3_00000001
1_1_000000ff
1_0_00000000
1_0_00000002
2_0_00000000
3_1_000003fe
3_2_00000003
// Load while the chip clock is stopped
1_1_00000001
1_2_00000155
1_3_000000e7
1_0_00000800
1_0_00000802
6_0_00000014
4_0_00000020
5_0_00000008
3_1_000003fe
3_2_00000003
1_0_00000002
2_0_00000000
3_1_000002ab
3_2_000000ce
4_0_00000000
0_0_00000000
